/* filelist.f */
+incdir+include
design/rename_pkg.sv
design/reg_file.sv
design/reorder_buffer.sv
design/operand_resolve.sv
design/rename_top.sv
tb/rename_checker.sv
tb/tb_rename.sv

/* tb/tb_rename.sv */
`timescale 1ns/10ps
`include "rename_macros.svh"

module tb_rename;

    localparam int TRAFFIC_CYCLES = 4000;
    localparam int READY_LIMIT    = 50;
    localparam int DRAIN_LIMIT    = 400;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  in_valid;
    logic                  in_ready;
    rename_pkg::op_class_e in_op;
    rename_pkg::addr_t     in_pc;
    rename_pkg::imm_t      in_imm;
    rename_pkg::reg_addr_t in_rd;
    rename_pkg::reg_addr_t in_rs1;
    rename_pkg::reg_addr_t in_rs2;
    logic                  out_valid;
    logic                  out_ready;
    rename_pkg::op_class_e out_op;
    rename_pkg::addr_t     out_pc;
    rename_pkg::imm_t      out_imm;
    rename_pkg::reg_addr_t out_rd;
    rename_pkg::tag_t      out_tag;
    rename_pkg::tag_t      out_rs1_tag;
    rename_pkg::data_t     out_rs1_data;
    rename_pkg::tag_t      out_rs2_tag;
    rename_pkg::data_t     out_rs2_data;
    logic                  wb_valid;
    rename_pkg::tag_t      wb_tag;
    rename_pkg::data_t     wb_data;
    logic                  commit_valid;
    rename_pkg::tag_t      commit_tag;
    rename_pkg::reg_addr_t commit_rd;
    rename_pkg::data_t     commit_data;

    int                    mismatch_cnt;
    int                    fault_cnt;
    int                    timeout_cnt;
    logic                  idle;
    logic [31:0]           seed;
    rename_pkg::tag_t      pending [$];   // Accepted tags with no writeback issued yet
    rename_pkg::tag_t      alloc_cnt;

    rename_top u_dut (.*);

    rename_checker u_checker (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Runs right after an edge and records what that edge accepted
    task automatic track_edge();
        if (flush) begin
            pending.delete();
            alloc_cnt = 1;
        end else if (in_valid && in_ready) begin
            pending.push_back(alloc_cnt);
            alloc_cnt = (alloc_cnt == `ROB_DEPTH) ? 1 : alloc_cnt + 1'b1;
        end
    endtask

    task automatic drive_cycle(input logic allow_in);
        logic go_flush;
        int   pick;
        seed = lcg_next(seed);
        in_valid  <= allow_in && (seed[31:30] != 2'b00);
        out_ready <= seed[29:28] != 2'b00;
        in_op     <= rename_pkg::op_class_e'(seed[27:25] % 3'd5);
        in_rd     <= rename_pkg::reg_addr_t'(seed[24:21]);   // Sixteen registers keep hazards dense
        in_rs1    <= rename_pkg::reg_addr_t'(seed[20:17]);
        in_rs2    <= rename_pkg::reg_addr_t'(seed[16:13]);
        seed = lcg_next(seed);
        go_flush = allow_in && (seed[31:25] == 7'd0);
        flush     <= go_flush;
        in_pc     <= {seed[29:0], 2'b00};
        seed = lcg_next(seed);
        in_imm    <= seed;
        seed = lcg_next(seed);
        if (!go_flush && pending.size() != 0 && seed[31:30] != 2'b00) begin
            pick = seed[23:8] % pending.size();
            wb_valid <= 1'b1;
            wb_tag   <= pending[pick];
            pending.delete(pick);
            seed = lcg_next(seed);
            wb_data  <= seed;
        end else begin
            wb_valid <= 1'b0;
        end
    endtask

    task automatic await_ready();
        int waited;
        waited = 0;
        while (!in_ready && waited < READY_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!in_ready) begin
            timeout_cnt++;
            $display("timeout: in_ready never rose after reset");
        end
    endtask

    // Stops new instructions and finishes every writeback until nothing is in flight
    task automatic drain();
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            track_edge();
            done = idle && (pending.size() == 0);
            drive_cycle(1'b0);
            waited++;
        end
        if (!done) begin
            timeout_cnt++;
            $display("timeout: reorder buffer did not empty after the traffic phase");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_op       = rename_pkg::op_alu;
        in_pc       = '0;
        in_imm      = '0;
        in_rd       = '0;
        in_rs1      = '0;
        in_rs2      = '0;
        out_ready   = 1'b0;
        wb_valid    = 1'b0;
        wb_tag      = '0;
        wb_data     = '0;
        seed        = 32'h56da_4aca;
        alloc_cnt   = 1;
        timeout_cnt = 0;

        repeat (16) @(posedge clk);
        rst <= 1'b0;
        await_ready();
        if (timeout_cnt == 0) begin
            for (int c = 0; c < TRAFFIC_CYCLES; c++) begin
                @(posedge clk);
                track_edge();
                drive_cycle(1'b1);
            end
            drain();
        end

        @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatch_cnt, fault_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && fault_cnt == 0 && timeout_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb/rename_checker.sv */
`timescale 1ns/10ps
`include "rename_macros.svh"

module rename_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  in_valid,
    input  logic                  in_ready,
    input  rename_pkg::op_class_e in_op,
    input  rename_pkg::addr_t     in_pc,
    input  rename_pkg::imm_t      in_imm,
    input  rename_pkg::reg_addr_t in_rd,
    input  rename_pkg::reg_addr_t in_rs1,
    input  rename_pkg::reg_addr_t in_rs2,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  rename_pkg::op_class_e out_op,
    input  rename_pkg::addr_t     out_pc,
    input  rename_pkg::imm_t      out_imm,
    input  rename_pkg::reg_addr_t out_rd,
    input  rename_pkg::tag_t      out_tag,
    input  rename_pkg::tag_t      out_rs1_tag,
    input  rename_pkg::data_t     out_rs1_data,
    input  rename_pkg::tag_t      out_rs2_tag,
    input  rename_pkg::data_t     out_rs2_data,
    input  logic                  wb_valid,
    input  rename_pkg::tag_t      wb_tag,
    input  rename_pkg::data_t     wb_data,
    input  logic                  commit_valid,
    input  rename_pkg::tag_t      commit_tag,
    input  rename_pkg::reg_addr_t commit_rd,
    input  rename_pkg::data_t     commit_data,
    output int                    mismatch_cnt,
    output int                    fault_cnt,
    output logic                  idle
);

    localparam int SRC_W = `TAG_W + `DATA_W;

    rename_pkg::data_t     arch [`REG_NUM];
    rename_pkg::tag_t      fl_tag  [$];   // In-flight instructions, oldest first
    rename_pkg::reg_addr_t fl_rd   [$];
    logic                  fl_done [$];
    rename_pkg::data_t     fl_data [$];

    rename_pkg::tag_t      next_tag;
    logic                  exp_valid;
    rename_pkg::op_class_e exp_op;
    rename_pkg::addr_t     exp_pc;
    rename_pkg::imm_t      exp_imm;
    rename_pkg::reg_addr_t exp_rd;
    rename_pkg::tag_t      exp_tag;
    logic [SRC_W-1:0]      exp_src1;
    logic [SRC_W-1:0]      exp_src2;
    logic                  head_done;
    int                    idx;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Newest older writer decides the source; returns {tag, data}
    function automatic logic [SRC_W-1:0] resolve_source(input rename_pkg::reg_addr_t rs);
        if (rs == '0) begin
            return '0;
        end
        for (int i = fl_rd.size() - 1; i >= 0; i--) begin
            if (fl_rd[i] == rs) begin
                if (fl_done[i]) begin
                    return {rename_pkg::tag_t'(0), fl_data[i]};
                end
                return {fl_tag[i], arch[rs]};
            end
        end
        return {rename_pkg::tag_t'(0), arch[rs]};
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            mismatch_cnt++;
            $display("mismatch %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic fault(input string what);
        fault_cnt++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic check_source(input string name, input logic [SRC_W-1:0] expected,
                                input rename_pkg::tag_t tag, input rename_pkg::data_t data);
        compare({name, " tag"}, expected[SRC_W-1 -: `TAG_W], tag);
        if (expected[SRC_W-1 -: `TAG_W] == '0) begin   // Data only counts once resolved
            compare({name, " data"}, expected[`DATA_W-1:0], data);
        end
    endtask

    task automatic clear_inflight();
        fl_tag.delete();
        fl_rd.delete();
        fl_done.delete();
        fl_data.delete();
        next_tag  = 1;
        exp_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-edge comparison on values from before the edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            clear_inflight();
            for (int i = 0; i < `REG_NUM; i++) begin
                arch[i] = '0;
            end
        end else begin
            compare("out_valid", exp_valid, out_valid);
            if (exp_valid && out_valid) begin
                compare("dispatch op", exp_op, out_op);
                compare("dispatch pc", exp_pc, out_pc);
                compare("dispatch imm", exp_imm, out_imm);
                compare("dispatch rd", exp_rd, out_rd);
                compare("dispatch tag", exp_tag, out_tag);
                check_source("dispatch rs1", exp_src1, out_rs1_tag, out_rs1_data);
                check_source("dispatch rs2", exp_src2, out_rs2_tag, out_rs2_data);
            end
            if (in_ready && fl_tag.size() == `ROB_DEPTH) begin
                fault("in_ready is high with the reorder buffer holding eight entries");
            end
            if (in_ready && out_valid && !out_ready) begin
                fault("in_ready is high while the dispatch register is held");
            end

            if (flush) begin
                if (commit_valid) begin
                    fault("commit_valid is high on a flush edge");
                end
                clear_inflight();
            end else begin
                if (in_valid && in_ready) begin
                    exp_valid = 1'b1;
                    exp_op    = in_op;
                    exp_pc    = in_pc;
                    exp_imm   = in_imm;
                    exp_rd    = in_rd;
                    exp_tag   = next_tag;
                    exp_src1  = resolve_source(in_rs1);
                    exp_src2  = resolve_source(in_rs2);
                end else if (out_ready) begin
                    exp_valid = 1'b0;
                end

                head_done = 1'b0;
                if (fl_tag.size() != 0) begin
                    head_done = fl_done[0];
                end
                if (commit_valid !== head_done) begin
                    fault($sformatf("commit_valid is %b while the oldest entry done is %b",
                                    commit_valid, head_done));
                end else if (head_done) begin
                    compare("commit tag", fl_tag[0], commit_tag);
                    compare("commit rd", fl_rd[0], commit_rd);
                    compare("commit data", fl_data[0], commit_data);
                    if (fl_rd[0] != '0) begin
                        arch[fl_rd[0]] = fl_data[0];
                    end
                    void'(fl_tag.pop_front());
                    void'(fl_rd.pop_front());
                    void'(fl_done.pop_front());
                    void'(fl_data.pop_front());
                end

                if (wb_valid) begin
                    idx = -1;
                    foreach (fl_tag[i]) begin
                        if (fl_tag[i] == wb_tag) begin
                            idx = i;
                        end
                    end
                    if (idx < 0 || fl_done[idx]) begin
                        fault($sformatf("writeback to tag %0d which is not waiting", wb_tag));
                    end else begin
                        fl_done[idx] = 1'b1;
                        fl_data[idx] = wb_data;
                    end
                end

                if (in_valid && in_ready) begin
                    fl_tag.push_back(next_tag);
                    fl_rd.push_back((in_op == rename_pkg::op_store) ? '0 : in_rd);
                    fl_done.push_back(1'b0);
                    fl_data.push_back('0);
                    next_tag = (next_tag == `ROB_DEPTH) ? 1 : next_tag + 1'b1;
                end
            end
        end
        idle <= (fl_tag.size() == 0);
    end

endmodule

/* design/rename_top.sv */
`timescale 1ns/10ps

module rename_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  rename_pkg::op_class_e in_op,
    input  rename_pkg::addr_t     in_pc,
    input  rename_pkg::imm_t      in_imm,
    input  rename_pkg::reg_addr_t in_rd,
    input  rename_pkg::reg_addr_t in_rs1,
    input  rename_pkg::reg_addr_t in_rs2,

    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::op_class_e out_op,
    output rename_pkg::addr_t     out_pc,
    output rename_pkg::imm_t      out_imm,
    output rename_pkg::reg_addr_t out_rd,
    output rename_pkg::tag_t      out_tag,
    output rename_pkg::tag_t      out_rs1_tag,
    output rename_pkg::data_t     out_rs1_data,
    output rename_pkg::tag_t      out_rs2_tag,
    output rename_pkg::data_t     out_rs2_data,

    input  logic                  wb_valid,
    input  rename_pkg::tag_t      wb_tag,
    input  rename_pkg::data_t     wb_data,

    output logic                  commit_valid,
    output rename_pkg::tag_t      commit_tag,
    output rename_pkg::reg_addr_t commit_rd,
    output rename_pkg::data_t     commit_data
);

    logic                  alloc_fire;
    logic                  full;
    rename_pkg::tag_t      alloc_tag;
    rename_pkg::reg_addr_t alloc_rd;

    rename_pkg::tag_t      rs1_tag;
    rename_pkg::tag_t      rs2_tag;
    rename_pkg::data_t     rs1_data;
    rename_pkg::data_t     rs2_data;

    logic                  q1_done;
    logic                  q2_done;
    rename_pkg::data_t     q1_data;
    rename_pkg::data_t     q2_data;

    // Retirement drives the commit port and the register file together
    reg_file u_reg_file (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .rs1_addr   (in_rs1),
        .rs2_addr   (in_rs2),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .alloc_fire (alloc_fire),
        .alloc_rd   (alloc_rd),
        .alloc_tag  (alloc_tag),
        .ret_valid  (commit_valid),
        .ret_rd     (commit_rd),
        .ret_tag    (commit_tag),
        .ret_data   (commit_data)
    );

    reorder_buffer u_rob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc_fire  (alloc_fire),
        .alloc_op    (in_op),
        .alloc_rd_in (in_rd),
        .alloc_tag   (alloc_tag),
        .alloc_rd    (alloc_rd),
        .full        (full),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_data     (wb_data),
        .q1_tag      (rs1_tag),
        .q2_tag      (rs2_tag),
        .q1_done     (q1_done),
        .q2_done     (q2_done),
        .q1_data     (q1_data),
        .q2_data     (q2_data),
        .ret_valid   (commit_valid),
        .ret_tag     (commit_tag),
        .ret_rd      (commit_rd),
        .ret_data    (commit_data)
    );

    operand_resolve u_operand (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .full         (full),
        .in_op        (in_op),
        .in_pc        (in_pc),
        .in_imm       (in_imm),
        .in_rd        (in_rd),
        .alloc_tag    (alloc_tag),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .q1_done      (q1_done),
        .q2_done      (q2_done),
        .q1_data      (q1_data),
        .q2_data      (q2_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_op       (out_op),
        .out_pc       (out_pc),
        .out_imm      (out_imm),
        .out_rd       (out_rd),
        .out_tag      (out_tag),
        .out_rs1_tag  (out_rs1_tag),
        .out_rs1_data (out_rs1_data),
        .out_rs2_tag  (out_rs2_tag),
        .out_rs2_data (out_rs2_data),
        .alloc_fire   (alloc_fire)
    );

endmodule

/* design/operand_resolve.sv */
`timescale 1ns/10ps

module operand_resolve (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  logic                  full,
    input  rename_pkg::op_class_e in_op,
    input  rename_pkg::addr_t     in_pc,
    input  rename_pkg::imm_t      in_imm,
    input  rename_pkg::reg_addr_t in_rd,
    input  rename_pkg::tag_t      alloc_tag,

    input  rename_pkg::tag_t      rs1_tag,
    input  rename_pkg::tag_t      rs2_tag,
    input  rename_pkg::data_t     rs1_data,
    input  rename_pkg::data_t     rs2_data,
    input  logic                  q1_done,
    input  logic                  q2_done,
    input  rename_pkg::data_t     q1_data,
    input  rename_pkg::data_t     q2_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output rename_pkg::op_class_e out_op,
    output rename_pkg::addr_t     out_pc,
    output rename_pkg::imm_t      out_imm,
    output rename_pkg::reg_addr_t out_rd,
    output rename_pkg::tag_t      out_tag,
    output rename_pkg::tag_t      out_rs1_tag,
    output rename_pkg::data_t     out_rs1_data,
    output rename_pkg::tag_t      out_rs2_tag,
    output rename_pkg::data_t     out_rs2_data,

    output logic                  alloc_fire
);

    logic live_q;     // Input stays closed until the first cycle after reset
    logic out_hold;   // Output register full and not draining

    ////////////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////////////

    assign out_hold   = out_valid && !out_ready;
    assign in_ready   = live_q && !full && !flush && !out_hold;
    assign alloc_fire = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            live_q    <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            live_q <= 1'b1;
            if (flush) begin
                out_valid <= 1'b0;
            end else if (alloc_fire) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Dispatch register
    ////////////////////////////////////////////////////////////////////////////

    // A done producer hands over its result and the source no longer waits
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            out_op       <= in_op;
            out_pc       <= in_pc;
            out_imm      <= in_imm;
            out_rd       <= in_rd;
            out_tag      <= alloc_tag;
            out_rs1_tag  <= q1_done ? '0 : rs1_tag;
            out_rs1_data <= q1_done ? q1_data : rs1_data;
            out_rs2_tag  <= q2_done ? '0 : rs2_tag;
            out_rs2_data <= q2_done ? q2_data : rs2_data;
        end
    end

endmodule

/* design/reorder_buffer.sv */
`timescale 1ns/10ps
`include "rename_macros.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,

    input  logic                   alloc_fire,
    input  rename_pkg::op_class_e  alloc_op,
    input  rename_pkg::reg_addr_t  alloc_rd_in,
    output rename_pkg::tag_t       alloc_tag,
    output rename_pkg::reg_addr_t  alloc_rd,
    output logic                   full,

    input  logic                   wb_valid,
    input  rename_pkg::tag_t       wb_tag,
    input  rename_pkg::data_t      wb_data,

    input  rename_pkg::tag_t       q1_tag,
    input  rename_pkg::tag_t       q2_tag,
    output logic                   q1_done,
    output logic                   q2_done,
    output rename_pkg::data_t      q1_data,
    output rename_pkg::data_t      q2_data,

    output logic                   ret_valid,
    output rename_pkg::tag_t       ret_tag,
    output rename_pkg::reg_addr_t  ret_rd,
    output rename_pkg::data_t      ret_data
);

    rename_pkg::rob_state_e state_q [`ROB_DEPTH];
    rename_pkg::reg_addr_t  rd_q    [`ROB_DEPTH];
    rename_pkg::data_t      data_q  [`ROB_DEPTH];

    logic [`ROB_IDX_W-1:0] head_q;
    logic [`ROB_IDX_W-1:0] tail_q;
    logic [`TAG_W-1:0]     count_q;   // Needs to reach the full depth

    logic [`ROB_IDX_W-1:0] wb_idx;
    logic [`ROB_IDX_W-1:0] q1_idx;
    logic [`ROB_IDX_W-1:0] q2_idx;

    function automatic logic [`ROB_IDX_W-1:0] tag_idx(input rename_pkg::tag_t tag);
        tag_idx = `ROB_IDX_W'(tag - 1'b1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Allocation side
    ////////////////////////////////////////////////////////////////////////////

    assign alloc_tag = rename_pkg::tag_t'(tail_q) + rename_pkg::tag_t'(1);
    assign alloc_rd  = (alloc_op == rename_pkg::op_store) ? '0 : alloc_rd_in;
    assign full      = count_q == `ROB_DEPTH;

    ////////////////////////////////////////////////////////////////////////////
    // Operand queries and retirement
    ////////////////////////////////////////////////////////////////////////////

    assign wb_idx = tag_idx(wb_tag);
    assign q1_idx = tag_idx(q1_tag);
    assign q2_idx = tag_idx(q2_tag);

    assign q1_done = (q1_tag != '0) && (state_q[q1_idx] == rename_pkg::rob_done);
    assign q2_done = (q2_tag != '0) && (state_q[q2_idx] == rename_pkg::rob_done);
    assign q1_data = data_q[q1_idx];
    assign q2_data = data_q[q2_idx];

    // A flush cycle retires nothing
    assign ret_valid = (state_q[head_q] == rename_pkg::rob_done) && !flush;
    assign ret_tag   = rename_pkg::tag_t'(head_q) + rename_pkg::tag_t'(1);
    assign ret_rd    = rd_q[head_q];
    assign ret_data  = data_q[head_q];

    ////////////////////////////////////////////////////////////////////////////
    // Entry state and pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= rename_pkg::rob_empty;
            end
        end else begin
            if (alloc_fire) begin
                state_q[tail_q] <= rename_pkg::rob_busy;
                tail_q          <= tail_q + 1'b1;
            end

            if (wb_valid) begin
                state_q[wb_idx] <= rename_pkg::rob_done;
            end

            if (ret_valid) begin
                state_q[head_q] <= rename_pkg::rob_empty;
                head_q          <= head_q + 1'b1;
            end

            case ({alloc_fire, ret_valid})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Destination and result payload
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[tail_q] <= alloc_rd;
        end
        if (wb_valid) begin
            data_q[wb_idx] <= wb_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc_fire |-> !full
    ) else $error("allocate with the reorder buffer full");

    // Execution may only report on an instruction that is still waiting
    a_wb_busy: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid |-> (wb_tag != '0) && (state_q[wb_idx] == rename_pkg::rob_busy)
    ) else $error("writeback to tag %0d which is not busy", wb_tag);

endmodule

/* design/reg_file.sv */
`timescale 1ns/10ps
`include "rename_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,

    input  rename_pkg::reg_addr_t rs1_addr,
    input  rename_pkg::reg_addr_t rs2_addr,
    output rename_pkg::data_t     rs1_data,
    output rename_pkg::data_t     rs2_data,
    output rename_pkg::tag_t      rs1_tag,
    output rename_pkg::tag_t      rs2_tag,

    input  logic                  alloc_fire,
    input  rename_pkg::reg_addr_t alloc_rd,
    input  rename_pkg::tag_t      alloc_tag,

    input  logic                  ret_valid,
    input  rename_pkg::reg_addr_t ret_rd,
    input  rename_pkg::tag_t      ret_tag,
    input  rename_pkg::data_t     ret_data
);

    rename_pkg::data_t reg_data [`REG_NUM];
    rename_pkg::tag_t  reg_tag  [`REG_NUM];

    logic alloc_wr;
    logic ret_wr;
    logic ret_match;

    ////////////////////////////////////////////////////////////////////////////
    // Write qualifiers
    ////////////////////////////////////////////////////////////////////////////

    assign alloc_wr  = alloc_fire && (alloc_rd != '0);   // x0 is never renamed
    assign ret_wr    = ret_valid && (ret_rd != '0);      // Stores retire with rd zero
    assign ret_match = reg_tag[ret_rd] == ret_tag;

    ////////////////////////////////////////////////////////////////////////////
    // Source lookup
    ////////////////////////////////////////////////////////////////////////////

    // Entry zero is never written, so x0 reads back zero data and no tag
    assign rs1_data = reg_data[rs1_addr];
    assign rs2_data = reg_data[rs2_addr];
    assign rs1_tag  = reg_tag[rs1_addr];
    assign rs2_tag  = reg_tag[rs2_addr];

    ////////////////////////////////////////////////////////////////////////////
    // Architectural data
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                reg_data[i] <= '0;
            end
        end else if (ret_wr) begin
            reg_data[ret_rd] <= ret_data;   // Commits arrive in program order
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pending producer tags
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                reg_tag[i] <= '0;
            end
        end else begin
            // A younger writer may already own the register
            if (ret_wr && ret_match) begin
                reg_tag[ret_rd] <= '0;
            end

            if (alloc_wr) begin
                reg_tag[alloc_rd] <= alloc_tag;   // Later assignment wins a same-edge clash
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // The register a retiring writer renamed still holds its tag or a younger one,
    // since only its own commit or a flush can clear it
    a_ret_tag_pending: assert property (
        @(posedge clk) disable iff (rst)
        ret_wr |-> (reg_tag[ret_rd] != '0)
    ) else $error("retire to x%0d with no pending tag", ret_rd);

endmodule

/* design/rename_pkg.sv */
`include "rename_macros.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`TAG_W-1:0]      tag_t;     // Zero means the value sits in the register file
    typedef logic [`ADDR_W-1:0]     addr_t;
    typedef logic [`IMM_W-1:0]      imm_t;

    ////////////////////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [`OP_W-1:0] {
        op_alu,
        op_load,
        op_store,   // Carries no destination
        op_branch,
        op_jump
    } op_class_e;

    // Life of one reorder buffer slot
    typedef enum logic [1:0] {
        rob_empty,
        rob_busy,
        rob_done
    } rob_state_e;

endpackage

/* include/rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

`define DATA_W      32
`define ADDR_W      32
`define IMM_W       32
`define OP_W        3

////////////////////////////////////////////////////////////////////////////
// Architectural registers
////////////////////////////////////////////////////////////////////////////

`define REG_NUM     32
`define REG_ADDR_W  5

////////////////////////////////////////////////////////////////////////////
// Reorder buffer geometry
////////////////////////////////////////////////////////////////////////////

`define ROB_DEPTH   8
`define ROB_IDX_W   3
`define TAG_W       4   // One bit wider than the index so zero can mean no producer

`endif
